// File: include/vga_settings.svh
`ifndef VGA_SETTINGS_SVH
`define VGA_SETTINGS_SVH

// Horizontal raster in pixel clocks
`define VGA_H_VISIBLE 640
`define VGA_H_FRONT 16
`define VGA_H_SYNC 96
`define VGA_H_WHOLE 800

// Vertical raster in lines
`define VGA_V_VISIBLE 480
`define VGA_V_FRONT 10
`define VGA_V_SYNC 2
`define VGA_V_WHOLE 525

// Edge filter window, top left quarter of the screen
`define VGA_WIN_WIDTH 320
`define VGA_WIN_HEIGHT 240

// Buttons
`define VGA_NUM_BUTTONS 2

// Debounce sampling period in clocks
`define VGA_DEBOUNCE_DIV 100000

// Consecutive high samples needed for a stable press
`define VGA_DEBOUNCE_TAPS 4

`endif

// File: logic/vga_pkg.sv
package vga_pkg;

    // Pixel or line coordinate, wide enough for 800 columns
    typedef logic [9:0] coord_t;

    // Position of each button in the button vector
    typedef enum logic [0:0] {
        BTN_FOCUS       = 1'b0,
        BTN_ROTATE2IDLE = 1'b1
    } button_idx_e;

endpackage

// File: logic/sample_tick_gen.sv
`timescale 1ns/1ps

module sample_tick_gen #(
    parameter int DIVIDE = 100000
) (
    input  logic clk,
    input  logic reset,
    output logic sample_tick
);

    localparam int CNT_W = $clog2(DIVIDE);

    logic [CNT_W-1:0] count;

    // Tick is registered on the wrap so it lands DIVIDE cycles after reset
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count       <= '0;
            sample_tick <= 1'b0;
        end else if (count == CNT_W'(DIVIDE - 1)) begin
            count       <= '0;
            sample_tick <= 1'b1;
        end else begin
            count       <= count + 1'b1;
            sample_tick <= 1'b0;
        end
    end

    a_tick_single : assert property (@(posedge clk) disable iff (reset)
        sample_tick |=> !sample_tick);

endmodule

// File: logic/button_debouncer.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module button_debouncer (
    input  logic clk,
    input  logic reset,
    input  logic sample_tick,
    input  logic button,
    output logic stable,
    output logic rise
);

    localparam int TAPS = `VGA_DEBOUNCE_TAPS;

    logic [TAPS-1:0] samples;
    logic            stable_d;

    // Newest sample enters at the top
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            samples <= '0;
        end else if (sample_tick) begin
            samples <= {button, samples[TAPS-1:1]};
        end
    end

    assign stable = &samples;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            stable_d <= 1'b0;
        end else begin
            stable_d <= stable;
        end
    end

    // Single cycle strobe on the first stable cycle
    assign rise = stable & ~stable_d;

    // Stable only changes right after a sample tick
    a_rise_stable : assert property (@(posedge clk) disable iff (reset)
        rise |-> stable && $past(sample_tick));

endmodule

// File: logic/command_pulser.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module command_pulser (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`VGA_NUM_BUTTONS-1:0] rise,
    output logic                        mean_start,
    output logic                        rotate2idle
);

    import vga_pkg::*;

    // One cycle behind the debouncer strobes
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            mean_start  <= 1'b0;
            rotate2idle <= 1'b0;
        end else begin
            mean_start  <= rise[BTN_FOCUS];
            rotate2idle <= rise[BTN_ROTATE2IDLE];
        end
    end

    a_mean_start_single : assert property (@(posedge clk) disable iff (reset)
        mean_start |=> !mean_start);

    a_rotate2idle_single : assert property (@(posedge clk) disable iff (reset)
        rotate2idle |=> !rotate2idle);

endmodule

// File: logic/raster_timing.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module raster_timing (
    input  logic            clk,
    input  logic            reset,
    output logic            h_sync,
    output logic            v_sync,
    output vga_pkg::coord_t x_pixel,
    output vga_pkg::coord_t y_pixel,
    output vga_pkg::coord_t w_x_pixel,
    output logic            display_enable,
    output logic            sobel_en
);

    import vga_pkg::*;

    localparam coord_t H_LAST       = coord_t'(`VGA_H_WHOLE - 1);
    localparam coord_t V_LAST       = coord_t'(`VGA_V_WHOLE - 1);
    localparam coord_t H_SYNC_START = coord_t'(`VGA_H_VISIBLE + `VGA_H_FRONT);
    localparam coord_t H_SYNC_END   = coord_t'(`VGA_H_VISIBLE + `VGA_H_FRONT + `VGA_H_SYNC);
    localparam coord_t V_SYNC_START = coord_t'(`VGA_V_VISIBLE + `VGA_V_FRONT);
    localparam coord_t V_SYNC_END   = coord_t'(`VGA_V_VISIBLE + `VGA_V_FRONT + `VGA_V_SYNC);
    localparam coord_t H_VISIBLE    = coord_t'(`VGA_H_VISIBLE);
    localparam coord_t V_VISIBLE    = coord_t'(`VGA_V_VISIBLE);
    localparam coord_t WIN_WIDTH    = coord_t'(`VGA_WIN_WIDTH);
    localparam coord_t WIN_HEIGHT   = coord_t'(`VGA_WIN_HEIGHT);

    coord_t h_count;
    coord_t v_count;
    logic   line_end;

    assign line_end = (h_count == H_LAST);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            h_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // Line advances once per column wrap
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            v_count <= '0;
        end else if (line_end) begin
            if (v_count == V_LAST) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end
    end

    // Column as seen by the filter, one clock late
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            w_x_pixel <= '0;
        end else begin
            w_x_pixel <= h_count;
        end
    end

    assign x_pixel = h_count;
    assign y_pixel = v_count;

    // Syncs are active low
    assign h_sync = !((h_count >= H_SYNC_START) && (h_count < H_SYNC_END));
    assign v_sync = !((v_count >= V_SYNC_START) && (v_count < V_SYNC_END));

    assign display_enable = (h_count < H_VISIBLE) && (v_count < V_VISIBLE);

    // Delayed column paired with the current line
    assign sobel_en = (w_x_pixel < WIN_WIDTH) && (v_count < WIN_HEIGHT);

    a_col_range : assert property (@(posedge clk) disable iff (reset)
        h_count < coord_t'(`VGA_H_WHOLE));

    a_line_range : assert property (@(posedge clk) disable iff (reset)
        v_count < coord_t'(`VGA_V_WHOLE));

endmodule

// File: logic/vga_controller.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module vga_controller #(
    parameter int DEBOUNCE_DIV = `VGA_DEBOUNCE_DIV
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            focusing_btn,
    input  logic            rotate2idle_btn,
    output logic            h_sync,
    output logic            v_sync,
    output vga_pkg::coord_t x_pixel,
    output vga_pkg::coord_t y_pixel,
    output vga_pkg::coord_t w_x_pixel,
    output logic            display_enable,
    output logic            sobel_en,
    output logic            mean_start,
    output logic            rotate2idle
);

    import vga_pkg::*;

    logic [`VGA_NUM_BUTTONS-1:0] buttons;
    logic [`VGA_NUM_BUTTONS-1:0] rise;
    logic                        sample_tick;

    assign buttons[BTN_FOCUS]       = focusing_btn;
    assign buttons[BTN_ROTATE2IDLE] = rotate2idle_btn;

    sample_tick_gen #(
        .DIVIDE(DEBOUNCE_DIV)
    ) u_tick (
        .clk        (clk),
        .reset      (reset),
        .sample_tick(sample_tick)
    );

    // One debouncer per button, all on the shared tick
    for (genvar i = 0; i < `VGA_NUM_BUTTONS; i++) begin : g_debounce
        button_debouncer u_debounce (
            .clk        (clk),
            .reset      (reset),
            .sample_tick(sample_tick),
            .button     (buttons[i]),
            .stable     (),
            .rise       (rise[i])
        );
    end

    command_pulser u_pulser (
        .clk        (clk),
        .reset      (reset),
        .rise       (rise),
        .mean_start (mean_start),
        .rotate2idle(rotate2idle)
    );

    raster_timing u_raster (
        .clk           (clk),
        .reset         (reset),
        .h_sync        (h_sync),
        .v_sync        (v_sync),
        .x_pixel       (x_pixel),
        .y_pixel       (y_pixel),
        .w_x_pixel     (w_x_pixel),
        .display_enable(display_enable),
        .sobel_en      (sobel_en)
    );

endmodule

// File: tb/vga_checker.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module vga_checker #(
    parameter int DIV = 8
) (
    input  logic            clk,
    input  logic            reset,
    input  int              focus_presses,
    input  int              rotate_presses,
    input  logic            h_sync,
    input  logic            v_sync,
    input  vga_pkg::coord_t x_pixel,
    input  vga_pkg::coord_t y_pixel,
    input  vga_pkg::coord_t w_x_pixel,
    input  logic            display_enable,
    input  logic            sobel_en,
    input  logic            mean_start,
    input  logic            rotate2idle,
    output int              error_total
);

    import vga_pkg::*;

    localparam int PULSE_LIMIT  = 5 * DIV + 2;
    localparam int WATCH_LIMIT  = 1000000;
    localparam int H_SYNC_START = `VGA_H_VISIBLE + `VGA_H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + `VGA_H_SYNC;
    localparam int V_SYNC_START = `VGA_V_VISIBLE + `VGA_V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + `VGA_V_SYNC;

    int   raster_errors = 0;
    int   window_errors = 0;
    int   command_errors = 0;
    int   model_col;
    int   model_line;
    int   model_prev_col;
    logic after_reset;
    logic prev_mean_start;
    logic prev_rotate2idle;

    assign error_total = raster_errors + window_errors + command_errors;

    function automatic int check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    // Sampled mid cycle, away from both the clock edge and the input changes
    always @(negedge clk) begin
        logic exp_h_sync;
        logic exp_v_sync;
        logic exp_enable;
        logic exp_window;
        if (reset) begin
            model_col        = 0;
            model_line       = 0;
            model_prev_col   = 0;
            after_reset      = 1'b1;
            prev_mean_start  = 1'b0;
            prev_rotate2idle = 1'b0;
            raster_errors   += check_value("x_pixel", 0, x_pixel);
            raster_errors   += check_value("y_pixel", 0, y_pixel);
            command_errors  += check_value("mean_start", 0, mean_start);
            command_errors  += check_value("rotate2idle", 0, rotate2idle);
        end else if (reset === 1'b0) begin
            if (after_reset) begin
                command_errors += check_value("mean_start", 0, mean_start);
                command_errors += check_value("rotate2idle", 0, rotate2idle);
                after_reset = 1'b0;
            end
            exp_h_sync = !(model_col >= H_SYNC_START && model_col < H_SYNC_END);
            exp_v_sync = !(model_line >= V_SYNC_START && model_line < V_SYNC_END);
            exp_enable = (model_col < `VGA_H_VISIBLE) && (model_line < `VGA_V_VISIBLE);
            exp_window = (model_prev_col < `VGA_WIN_WIDTH) && (model_line < `VGA_WIN_HEIGHT);
            raster_errors += check_value("x_pixel", model_col, x_pixel);
            raster_errors += check_value("y_pixel", model_line, y_pixel);
            raster_errors += check_value("h_sync", exp_h_sync, h_sync);
            raster_errors += check_value("v_sync", exp_v_sync, v_sync);
            raster_errors += check_value("display_enable", exp_enable, display_enable);
            window_errors += check_value("w_x_pixel", model_prev_col, w_x_pixel);
            window_errors += check_value("sobel_en", exp_window, sobel_en);
            if (mean_start && prev_mean_start) begin
                $display("%0t: mean_start stayed high for two cycles in a row", $time);
                command_errors++;
            end
            if (rotate2idle && prev_rotate2idle) begin
                $display("%0t: rotate2idle stayed high for two cycles in a row", $time);
                command_errors++;
            end
            prev_mean_start  = mean_start;
            prev_rotate2idle = rotate2idle;
            model_prev_col   = model_col;
            if (model_col == `VGA_H_WHOLE - 1) begin
                model_col  = 0;
                model_line = (model_line == `VGA_V_WHOLE - 1) ? 0 : model_line + 1;
            end else begin
                model_col++;
            end
        end
    end

    function automatic logic command_level(input int b);
        return (b == int'(BTN_FOCUS)) ? mean_start : rotate2idle;
    endfunction

    function automatic int press_events(input int b);
        return (b == int'(BTN_FOCUS)) ? focus_presses : rotate_presses;
    endfunction

    // A pulse is only legal while a press is waiting for it
    task automatic watch_commands(input int b, input string name);
        int   seen_presses;
        int   cycles;
        int   waited;
        logic got_pulse;
        seen_presses = 0;
        cycles       = 0;
        while (cycles < WATCH_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (!reset && command_level(b)) begin
                $display("%0t: %s pulsed with no press pending", $time, name);
                command_errors++;
            end
            if (press_events(b) != seen_presses) begin
                seen_presses = press_events(b);
                waited    = 0;
                got_pulse = 1'b0;
                while (!got_pulse && waited < PULSE_LIMIT) begin
                    @(negedge clk);
                    waited++;
                    cycles++;
                    got_pulse = command_level(b);
                end
                if (!got_pulse) begin
                    $display("%0t: no %s pulse within %0d cycles of a press",
                             $time, name, PULSE_LIMIT);
                    command_errors++;
                end
            end
        end
    endtask

    initial watch_commands(int'(BTN_FOCUS), "mean_start");
    initial watch_commands(int'(BTN_ROTATE2IDLE), "rotate2idle");

    task automatic print_counts();
        $display("Errors: raster %0d, window %0d, command %0d (presses %0d focus, %0d rotate)",
                 raster_errors, window_errors, command_errors, focus_presses, rotate_presses);
    endtask

endmodule

// File: tb/tb_vga_controller.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module tb_clock_gen #(
    parameter int HALF_PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

module tb_vga_controller;

    import vga_pkg::*;

    localparam int  DIV          = 8;
    localparam int  RUN_CYCLES   = 900000;
    localparam int  LIMIT_CYCLES = 1000000;
    localparam time DRIVE_DELAY  = 2ns;

    logic   clk;
    logic   reset;
    logic   focusing_btn;
    logic   rotate2idle_btn;
    logic   h_sync;
    logic   v_sync;
    coord_t x_pixel;
    coord_t y_pixel;
    coord_t w_x_pixel;
    logic   display_enable;
    logic   sobel_en;
    logic   mean_start;
    logic   rotate2idle;

    int          focus_presses;
    int          rotate_presses;
    int          error_total;
    int          cycle_count;
    logic [31:0] lfsr_state;

    tb_clock_gen u_clock (
        .clk(clk)
    );

    vga_controller #(
        .DEBOUNCE_DIV(DIV)
    ) UUT (
        .clk            (clk),
        .reset          (reset),
        .focusing_btn   (focusing_btn),
        .rotate2idle_btn(rotate2idle_btn),
        .h_sync         (h_sync),
        .v_sync         (v_sync),
        .x_pixel        (x_pixel),
        .y_pixel        (y_pixel),
        .w_x_pixel      (w_x_pixel),
        .display_enable (display_enable),
        .sobel_en       (sobel_en),
        .mean_start     (mean_start),
        .rotate2idle    (rotate2idle)
    );

    vga_checker #(
        .DIV(DIV)
    ) u_checker (
        .clk            (clk),
        .reset          (reset),
        .focus_presses  (focus_presses),
        .rotate_presses (rotate_presses),
        .h_sync         (h_sync),
        .v_sync         (v_sync),
        .x_pixel        (x_pixel),
        .y_pixel        (y_pixel),
        .w_x_pixel      (w_x_pixel),
        .display_enable (display_enable),
        .sobel_en       (sobel_en),
        .mean_start     (mean_start),
        .rotate2idle    (rotate2idle),
        .error_total    (error_total)
    );

    // Right-shifting Galois form
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'hA3000000) : (state >> 1);
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // Returns just after a rising edge, where inputs change
    task automatic wait_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            cycle_count++;
        end
    endtask

    task automatic set_button(input int b, input logic level);
        if (b == int'(BTN_FOCUS)) begin
            focusing_btn = level;
        end else begin
            rotate2idle_btn = level;
        end
    endtask

    task automatic long_press(input int b);
        int extra;
        take_bits(5, extra);
        set_button(b, 1'b1);
        if (b == int'(BTN_FOCUS)) begin
            focus_presses++;
        end else begin
            rotate_presses++;
        end
        wait_cycles(6 * DIV + extra);
        set_button(b, 1'b0);
        take_bits(5, extra);
        wait_cycles(6 * DIV + extra);
    endtask

    // High for 1 to 7 clocks, always shorter than one tick period
    task automatic glitch(input int b);
        int width;
        int extra;
        take_bits(3, width);
        set_button(b, 1'b1);
        wait_cycles(1 + (width % 7));
        set_button(b, 1'b0);
        take_bits(4, extra);
        wait_cycles(6 * DIV + extra);
    endtask

    initial begin
        int kind;
        int b;
        int gap;
        lfsr_state      = 32'h465571d8;
        reset           = 1'b1;
        focusing_btn    = 1'b0;
        rotate2idle_btn = 1'b0;
        focus_presses   = 0;
        rotate_presses  = 0;
        cycle_count     = 0;
        repeat (2) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
        wait_cycles(6 * DIV);
        while (cycle_count < RUN_CYCLES) begin
            take_bits(2, kind);
            take_bits(1, b);
            if (kind == 0) begin
                long_press(b);
            end else if (kind == 1) begin
                glitch(b);
            end else begin
                take_bits(6, gap);
                wait_cycles(1 + gap);
            end
        end
        wait_cycles(2);
        u_checker.print_counts();
        if (error_total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        int waited;
        waited = 0;
        while (waited < LIMIT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        $display("Simulation timed out after %0d cycles", LIMIT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
logic/vga_pkg.sv
logic/sample_tick_gen.sv
logic/button_debouncer.sv
logic/command_pulser.sv
logic/raster_timing.sv
logic/vga_controller.sv
tb/vga_checker.sv
tb/tb_vga_controller.sv

// File: Bender.yml
package:
  name: vga_controller

sources:
  - include_dirs:
      - include
    files:
      - logic/vga_pkg.sv
      - logic/sample_tick_gen.sv
      - logic/button_debouncer.sv
      - logic/command_pulser.sv
      - logic/raster_timing.sv
      - logic/vga_controller.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/vga_checker.sv
      - tb/tb_vga_controller.sv
